//--- hw/br_defs.svh
`ifndef BR_DEFS_SVH
`define BR_DEFS_SVH

////////////////////////////////////////
// datapath and register file sizes
////////////////////////////////////////

`define BR_XLEN         32
`define BR_PREG_NUM     64
`define BR_PREG_IDX     6

////////////////////////////////////////
// reservation station and ROB tags
////////////////////////////////////////

`define BR_RS_DEPTH     4
`define BR_RS_IDX       2
`define BR_ROB_IDX      4

// lane 0 external writeback, lane 1 branch unit
`define BR_CDB_WIDTH    2

`endif

//--- hw/br_pkg.sv
`include "br_defs.svh"

package br_pkg;

    ////////////////////////////////////////
    // operand and operation encodings
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        OP1_ZERO = 2'd0,
        OP1_PC   = 2'd1,
        OP1_RS1  = 2'd2
    } op1_sel_t;

    typedef enum logic [1:0] {
        OP2_ZERO = 2'd0,
        OP2_IMM  = 2'd1,
        OP2_RS2  = 2'd2
    } op2_sel_t;

    typedef enum logic [2:0] {
        BEQ  = 3'd0,
        BNE  = 3'd1,
        BLT  = 3'd2,
        BGE  = 3'd3,
        BLTU = 3'd4,
        BGEU = 3'd5,
        JAL  = 3'd6,
        JALR = 3'd7
    } br_op_t;

    ////////////////////////////////////////
    // bundles between stages
    ////////////////////////////////////////

    // renamed micro-op as held in a station entry
    typedef struct packed {
        logic [`BR_ROB_IDX-1:0]  rob_id;
        logic [`BR_PREG_IDX-1:0] rd_phy;
        logic [4:0]              rd_arch;
        br_op_t                  br_op;
        op1_sel_t                op1_sel;
        op2_sel_t                op2_sel;
        logic [`BR_PREG_IDX-1:0] rs1_phy;
        logic                    rs1_valid;
        logic [`BR_PREG_IDX-1:0] rs2_phy;
        logic                    rs2_valid;
        logic [`BR_XLEN-1:0]     imm;
        logic [`BR_XLEN-1:0]     pc;
        logic                    predict_taken;
        logic [`BR_XLEN-1:0]     predict_target;
    } br_uop_t;

    // one writeback lane
    typedef struct packed {
        logic                    valid;
        logic [`BR_PREG_IDX-1:0] rd_phy;
        logic [4:0]              rd_arch;
        logic [`BR_ROB_IDX-1:0]  rob_id;
        logic [`BR_XLEN-1:0]     value;
    } cdb_t;

    // station to branch unit, operands already read
    typedef struct packed {
        logic [`BR_ROB_IDX-1:0]  rob_id;
        logic [`BR_PREG_IDX-1:0] rd_phy;
        logic [4:0]              rd_arch;
        br_op_t                  br_op;
        logic [`BR_XLEN-1:0]     imm;
        logic [`BR_XLEN-1:0]     pc;
        logic                    predict_taken;
        logic [`BR_XLEN-1:0]     predict_target;
        logic [`BR_XLEN-1:0]     rs1_value;
        logic [`BR_XLEN-1:0]     rs2_value;
    } br_issue_t;

    typedef struct packed {
        logic                    valid;
        logic [`BR_ROB_IDX-1:0]  rob_id;
        logic                    taken;
        logic [`BR_XLEN-1:0]     target;
        logic                    mispredict;
    } br_resolve_t;

endpackage

//--- hw/br_phys_regfile.sv
`timescale 1ns/10ps
`include "br_defs.svh"

module br_phys_regfile (
    input  logic                    clk,
    input  logic                    rst,
    input  br_pkg::cdb_t            cdb [`BR_CDB_WIDTH],
    input  logic [`BR_PREG_IDX-1:0] rs1_phy,
    input  logic [`BR_PREG_IDX-1:0] rs2_phy,
    output logic [`BR_XLEN-1:0]     rs1_value,
    output logic [`BR_XLEN-1:0]     rs2_value
);

    logic [`BR_XLEN-1:0]     regs    [`BR_PREG_NUM];

    // both read ports handled by one loop
    logic [`BR_PREG_IDX-1:0] rd_idx  [2];
    logic [`BR_XLEN-1:0]     rd_data [2];

    ////////////////////////////////////////
    // write from every CDB lane
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `BR_PREG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // p0 is never a legal destination
            for (int k = 0; k < `BR_CDB_WIDTH; k++) begin
                if (cdb[k].valid && (cdb[k].rd_phy != '0)) begin
                    regs[cdb[k].rd_phy] <= cdb[k].value;
                end
            end
        end
    end

    ////////////////////////////////////////
    // combinational read with CDB forward
    ////////////////////////////////////////

    assign rd_idx[0] = rs1_phy;
    assign rd_idx[1] = rs2_phy;

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            rd_data[p] = regs[rd_idx[p]];
            // value written this cycle wins over the stored one
            for (int k = 0; k < `BR_CDB_WIDTH; k++) begin
                if (cdb[k].valid && (cdb[k].rd_phy != '0) && (cdb[k].rd_phy == rd_idx[p])) begin
                    rd_data[p] = cdb[k].value;
                end
            end
            if (rd_idx[p] == '0) begin
                rd_data[p] = '0;
            end
        end
    end

    assign rs1_value = rd_data[0];
    assign rs2_value = rd_data[1];

endmodule

//--- hw/br_fu.sv
`timescale 1ns/10ps
`include "br_defs.svh"

module br_fu (
    input  logic                clk,
    input  logic                rst,
    input  logic                issue_valid,
    input  br_pkg::br_issue_t   issue,
    output br_pkg::cdb_t        cdb_out,
    output br_pkg::br_resolve_t resolve
);
    import br_pkg::*;

    localparam logic [`BR_XLEN-1:0] LINK_OFFSET = 4;

    logic [`BR_XLEN-1:0] target_base;
    logic [`BR_XLEN-1:0] target_sum;
    logic [`BR_XLEN-1:0] target;
    logic [`BR_XLEN-1:0] link_value;
    logic                taken;
    logic                mispredict;

    ////////////////////////////////////////
    // outcome and target
    ////////////////////////////////////////

    // only JALR adds to a register, the rest are pc relative
    assign target_base = (issue.br_op == JALR) ? issue.rs1_value : issue.pc;
    assign target_sum  = target_base + issue.imm;
    assign target      = (issue.br_op == JALR) ? {target_sum[`BR_XLEN-1:1], 1'b0} : target_sum;
    assign link_value  = issue.pc + LINK_OFFSET;

    always_comb begin
        unique case (issue.br_op)
            BEQ:  taken = (issue.rs1_value == issue.rs2_value);
            BNE:  taken = (issue.rs1_value != issue.rs2_value);
            BLT:  taken = ($signed(issue.rs1_value) < $signed(issue.rs2_value));
            BGE:  taken = ($signed(issue.rs1_value) >= $signed(issue.rs2_value));
            BLTU: taken = (issue.rs1_value < issue.rs2_value);
            BGEU: taken = (issue.rs1_value >= issue.rs2_value);
            JAL,
            JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // wrong direction, or right direction to the wrong place
    assign mispredict = (taken != issue.predict_taken)
        || (taken && (target != issue.predict_target));

    ////////////////////////////////////////
    // result register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            cdb_out.valid <= 1'b0;
            resolve.valid <= 1'b0;
        end else begin
            // no writeback to p0
            cdb_out.valid <= issue_valid && (issue.rd_phy != '0);
            resolve.valid <= issue_valid;
        end
        if (issue_valid) begin
            cdb_out.rd_phy     <= issue.rd_phy;
            cdb_out.rd_arch    <= issue.rd_arch;
            cdb_out.rob_id     <= issue.rob_id;
            cdb_out.value      <= link_value;
            resolve.rob_id     <= issue.rob_id;
            resolve.taken      <= taken;
            resolve.target     <= target;
            resolve.mispredict <= mispredict;
        end
    end

endmodule

//--- hw/br_rs.sv
`timescale 1ns/10ps
`include "br_defs.svh"

module br_rs (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    dispatch_valid,
    input  br_pkg::br_uop_t         dispatch_uop,
    output logic                    dispatch_ready,
    input  br_pkg::cdb_t            cdb [`BR_CDB_WIDTH],
    output logic [`BR_PREG_IDX-1:0] rs1_phy,
    output logic [`BR_PREG_IDX-1:0] rs2_phy,
    input  logic [`BR_XLEN-1:0]     rs1_value,
    input  logic [`BR_XLEN-1:0]     rs2_value,
    output br_pkg::cdb_t            fu_cdb,
    output br_pkg::br_resolve_t     resolve
);
    import br_pkg::*;

    localparam int RS_IDX = `BR_RS_IDX;

    br_uop_t                 entries    [`BR_RS_DEPTH];
    logic [`BR_RS_DEPTH-1:0] entry_free;

    // wakeup matches against the current CDB
    logic [`BR_RS_DEPTH-1:0] rs1_hit;
    logic [`BR_RS_DEPTH-1:0] rs2_hit;
    logic [`BR_RS_DEPTH-1:0] entry_ready;
    br_uop_t                 push_uop;

    logic                    push_en;
    logic [RS_IDX-1:0]       push_idx;
    logic                    issue_en;
    logic [RS_IDX-1:0]       issue_idx;
    br_issue_t               issue_pkt;

    ////////////////////////////////////////
    // CDB snoop and ready check
    ////////////////////////////////////////

    always_comb begin
        rs1_hit  = '0;
        rs2_hit  = '0;
        push_uop = dispatch_uop;
        for (int k = 0; k < `BR_CDB_WIDTH; k++) begin
            if (cdb[k].valid && (cdb[k].rd_phy != '0)) begin
                for (int i = 0; i < `BR_RS_DEPTH; i++) begin
                    if (entries[i].rs1_phy == cdb[k].rd_phy) rs1_hit[i] = 1'b1;
                    if (entries[i].rs2_phy == cdb[k].rd_phy) rs2_hit[i] = 1'b1;
                end
                // incoming uop may name a tag broadcast this very cycle
                if (dispatch_uop.rs1_phy == cdb[k].rd_phy) push_uop.rs1_valid = 1'b1;
                if (dispatch_uop.rs2_phy == cdb[k].rd_phy) push_uop.rs2_valid = 1'b1;
            end
        end
    end

    // a source counts as ready with the bypass from the CDB
    always_comb begin
        for (int i = 0; i < `BR_RS_DEPTH; i++) begin
            entry_ready[i] = !entry_free[i]
                && ((entries[i].op1_sel != OP1_RS1) || entries[i].rs1_valid || rs1_hit[i])
                && ((entries[i].op2_sel != OP2_RS2) || entries[i].rs2_valid || rs2_hit[i]);
        end
    end

    ////////////////////////////////////////
    // push and issue select
    ////////////////////////////////////////

    assign dispatch_ready = |entry_free;

    always_comb begin
        push_en  = 1'b0;
        push_idx = '0;
        for (int i = 0; i < `BR_RS_DEPTH; i++) begin
            if (dispatch_valid && entry_free[i] && !push_en) begin
                push_en  = 1'b1;
                push_idx = RS_IDX'(i);
            end
        end
    end

    // lowest index wins
    always_comb begin
        issue_en  = 1'b0;
        issue_idx = '0;
        for (int i = 0; i < `BR_RS_DEPTH; i++) begin
            if (entry_ready[i] && !issue_en) begin
                issue_en  = 1'b1;
                issue_idx = RS_IDX'(i);
            end
        end
    end

    ////////////////////////////////////////
    // entry state
    ////////////////////////////////////////

    // issue over snoop over push
    always_ff @(posedge clk) begin
        if (rst) begin
            entry_free <= '1;
        end else begin
            if (push_en) entry_free[push_idx] <= 1'b0;
            if (issue_en) entry_free[issue_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push_en) begin
            entries[push_idx] <= push_uop;
        end
        for (int i = 0; i < `BR_RS_DEPTH; i++) begin
            if (!entry_free[i]) begin
                if (rs1_hit[i]) entries[i].rs1_valid <= 1'b1;
                if (rs2_hit[i]) entries[i].rs2_valid <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // operand read and branch unit
    ////////////////////////////////////////

    assign rs1_phy = entries[issue_idx].rs1_phy;
    assign rs2_phy = entries[issue_idx].rs2_phy;

    always_comb begin
        issue_pkt.rob_id         = entries[issue_idx].rob_id;
        issue_pkt.rd_phy         = entries[issue_idx].rd_phy;
        issue_pkt.rd_arch        = entries[issue_idx].rd_arch;
        issue_pkt.br_op          = entries[issue_idx].br_op;
        issue_pkt.imm            = entries[issue_idx].imm;
        issue_pkt.pc             = entries[issue_idx].pc;
        issue_pkt.predict_taken  = entries[issue_idx].predict_taken;
        issue_pkt.predict_target = entries[issue_idx].predict_target;
        issue_pkt.rs1_value      = rs1_value;
        issue_pkt.rs2_value      = rs2_value;
    end

    br_fu u_br_fu (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_en),
        .issue       (issue_pkt),
        .cdb_out     (fu_cdb),
        .resolve     (resolve)
    );

endmodule

//--- hw/br_issue_top.sv
`timescale 1ns/10ps
`include "br_defs.svh"

module br_issue_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                dispatch_valid,
    input  br_pkg::br_uop_t     dispatch_uop,
    output logic                dispatch_ready,
    input  br_pkg::cdb_t        ext_cdb,
    output br_pkg::cdb_t        cdb_out,
    output br_pkg::br_resolve_t resolve
);
    import br_pkg::*;

    cdb_t                    cdb_lanes [`BR_CDB_WIDTH];
    cdb_t                    fu_cdb;
    logic [`BR_PREG_IDX-1:0] rs1_phy;
    logic [`BR_PREG_IDX-1:0] rs2_phy;
    logic [`BR_XLEN-1:0]     rs1_value;
    logic [`BR_XLEN-1:0]     rs2_value;

    ////////////////////////////////////////
    // CDB lanes
    ////////////////////////////////////////

    assign cdb_lanes[0] = ext_cdb;
    assign cdb_lanes[1] = fu_cdb;
    assign cdb_out      = fu_cdb;

    br_phys_regfile u_regfile (
        .clk       (clk),
        .rst       (rst),
        .cdb       (cdb_lanes),
        .rs1_phy   (rs1_phy),
        .rs2_phy   (rs2_phy),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value)
    );

    br_rs u_br_rs (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_uop   (dispatch_uop),
        .dispatch_ready (dispatch_ready),
        .cdb            (cdb_lanes),
        .rs1_phy        (rs1_phy),
        .rs2_phy        (rs2_phy),
        .rs1_value      (rs1_value),
        .rs2_value      (rs2_value),
        .fu_cdb         (fu_cdb),
        .resolve        (resolve)
    );

endmodule

//--- verification/br_issue_tb.sv
`timescale 1ns/10ps
`include "br_defs.svh"

module br_issue_tb;
    import br_pkg::*;

    localparam int CLK_PERIOD    = 100;
    localparam int RESET_CYCLES  = 8;
    localparam int PRELOAD_REGS  = 12;
    localparam int UOPS_PER_TEST = 24;
    localparam int N_TESTS       = 5;
    localparam int TOTAL_UOPS    = UOPS_PER_TEST * N_TESTS;
    localparam int ROB_NUM       = 1 << `BR_ROB_IDX;
    localparam int RNG_SEED      = 32'ha230;

    localparam int MODE_COND    = 0;
    localparam int MODE_JUMP    = 1;
    localparam int MODE_PREDICT = 2;
    localparam int MODE_WAKEUP  = 3;
    localparam int MODE_FULL    = 4;

    logic        clk;
    logic        rst;
    logic        dispatch_valid;
    br_uop_t     dispatch_uop;
    logic        dispatch_ready;
    cdb_t        ext_cdb;
    cdb_t        cdb_out;
    br_resolve_t resolve;

    // renamer view of the physical registers
    logic [`BR_XLEN-1:0] reg_value [`BR_PREG_NUM];
    logic                reg_ready [`BR_PREG_NUM];
    br_uop_t             rob_uop   [ROB_NUM];
    logic                rob_busy  [ROB_NUM];
    int                  pending_q [$];

    int next_free;
    int last_dest;
    int dispatched;
    int resolved;
    int cycle;
    int checks;
    int errors;

    br_issue_top uut (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_uop   (dispatch_uop),
        .dispatch_ready (dispatch_ready),
        .ext_cdb        (ext_cdb),
        .cdb_out        (cdb_out),
        .resolve        (resolve)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TOTAL_UOPS * 20 * CLK_PERIOD);
        $display("ERROR: simulation hung, not all micro-ops resolved in time");
        $display("STATUS: FAIL");
        $finish;
    end

    ////////////////////////////////////////
    // checking helpers
    ////////////////////////////////////////

    task automatic log_mismatch(input string msg);
        errors++;
        $display("FAILED at %0t: %s", $time, msg);
    endtask

    task automatic check_that(input logic ok, input string msg);
        checks++;
        assert (ok) else log_mismatch(msg);
    endtask

    // edge values show up often so signed and unsigned compares differ
    function automatic logic [`BR_XLEN-1:0] pick_value();
        int sel;
        sel = $urandom_range(0, 7);
        case (sel)
            0: return 32'h0000_0000;
            1: return 32'h0000_0001;
            2: return 32'h7fff_ffff;
            3: return 32'h8000_0000;
            4: return 32'hffff_ffff;
            default: return $urandom;
        endcase
    endfunction

    function automatic br_resolve_t expected_resolve(br_uop_t u);
        br_resolve_t r;
        logic [`BR_XLEN-1:0] a;
        logic [`BR_XLEN-1:0] b;
        a = reg_value[u.rs1_phy];
        b = reg_value[u.rs2_phy];
        r = '0;
        r.valid = 1'b1;
        r.rob_id = u.rob_id;
        r.target = u.pc + u.imm;
        case (u.br_op)
            BEQ:  r.taken = (a == b);
            BNE:  r.taken = !(a == b);
            BLT:  r.taken = ($signed(a) < $signed(b));
            BGE:  r.taken = !($signed(a) < $signed(b));
            BLTU: r.taken = (a < b);
            BGEU: r.taken = !(a < b);
            JAL:  r.taken = 1'b1;
            default: begin
                r.taken = 1'b1;
                r.target = (a + u.imm) & 32'hffff_fffe;
            end
        endcase
        r.mispredict = (r.taken != u.predict_taken)
            || (r.taken && (r.target != u.predict_target));
        return r;
    endfunction

    ////////////////////////////////////////
    // clock step and response check
    ////////////////////////////////////////

    task automatic tick_and_check();
        br_resolve_t exp;
        br_uop_t     u;
        logic        src_ok;
        @(posedge clk);
        #1;
        cycle++;
        if (!resolve.valid) begin
            check_that(!cdb_out.valid, "CDB writeback without a resolve");
        end else if (!rob_busy[resolve.rob_id]) begin
            check_that(1'b0, "resolve for a rob_id that is not outstanding");
        end else begin
            u = rob_uop[resolve.rob_id];
            src_ok = ((u.op1_sel != OP1_RS1) || reg_ready[u.rs1_phy])
                && ((u.op2_sel != OP2_RS2) || reg_ready[u.rs2_phy]);
            check_that(src_ok, "micro-op resolved before its sources were written");
            exp = expected_resolve(u);
            check_that(resolve.taken == exp.taken, "taken differs from model");
            check_that(resolve.target == exp.target, "target differs from model");
            check_that(resolve.mispredict == exp.mispredict, "mispredict differs from model");
            check_that(cdb_out.valid == (u.rd_phy != '0), "link writeback valid is wrong");
            if (cdb_out.valid) begin
                check_that(cdb_out.rd_phy == u.rd_phy, "link writeback register is wrong");
                check_that(cdb_out.rd_arch == u.rd_arch, "link writeback rd_arch is wrong");
                check_that(cdb_out.value == u.pc + 32'd4, "link value is not pc+4");
                check_that(cdb_out.rob_id == u.rob_id, "link writeback rob_id is wrong");
            end
            if (u.rd_phy != '0) begin
                reg_value[u.rd_phy] = u.pc + 32'd4;
                reg_ready[u.rd_phy] = 1'b1;
            end
            rob_busy[resolve.rob_id] = 1'b0;
            resolved++;
        end
        // the entry behind this resolve was freed at the same edge
        check_that(dispatch_ready == ((dispatched - resolved) < `BR_RS_DEPTH),
                   "dispatch_ready does not match station occupancy");
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    task automatic apply_reset();
        rst = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_uop = '0;
        ext_cdb = '0;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #1;
            check_that(dispatch_ready && !resolve.valid && !cdb_out.valid,
                       "outputs wrong during reset");
        end
        rst = 1'b0;
        for (int i = 0; i < `BR_PREG_NUM; i++) begin
            reg_value[i] = '0;
            reg_ready[i] = 1'b1;
        end
        for (int i = 0; i < ROB_NUM; i++) begin
            rob_busy[i] = 1'b0;
        end
        pending_q.delete();
        next_free = PRELOAD_REGS + 1;
        last_dest = 0;
        dispatched = 0;
        resolved = 0;
    endtask

    task automatic drive_ext_write(input int preg);
        logic [`BR_XLEN-1:0] val;
        val = pick_value();
        ext_cdb = '0;
        ext_cdb.valid = 1'b1;
        ext_cdb.rd_phy = `BR_PREG_IDX'(preg);
        ext_cdb.rd_arch = 5'($urandom_range(1, 31));
        ext_cdb.value = val;
        reg_value[preg] = val;
        reg_ready[preg] = 1'b1;
    endtask

    task automatic preload_regs();
        for (int r = 1; r <= PRELOAD_REGS; r++) begin
            drive_ext_write(r);
            tick_and_check();
        end
        ext_cdb = '0;
    endtask

    // ready preloaded register, the last destination, or a fresh external one
    task automatic pick_source(input int pending_pct, input int uops_left,
                               output logic [`BR_PREG_IDX-1:0] src);
        src = `BR_PREG_IDX'($urandom_range(1, PRELOAD_REGS));
        if ($urandom_range(0, 99) < pending_pct) begin
            if (($urandom_range(0, 1) == 0) && !reg_ready[last_dest]) begin
                src = `BR_PREG_IDX'(last_dest);
            end else if (next_free + uops_left < `BR_PREG_NUM) begin
                src = `BR_PREG_IDX'(next_free);
                reg_ready[next_free] = 1'b0;
                pending_q.push_back(next_free);
                next_free++;
            end
        end
    endtask

    task automatic make_uop(input int mode, input int seq, output br_uop_t u);
        int op_lo;
        int op_hi;
        int pct;
        op_lo = (mode == MODE_JUMP) ? 6 : 0;
        op_hi = (mode == MODE_COND || mode == MODE_FULL) ? 5 : 7;
        pct = (mode == MODE_WAKEUP) ? 60 : ((mode == MODE_FULL) ? 100 : 0);
        u = '0;
        u.rob_id = `BR_ROB_IDX'(seq % ROB_NUM);
        u.br_op = br_op_t'(3'($urandom_range(op_lo, op_hi)));
        u.op1_sel = (u.br_op == JAL) ? OP1_PC : OP1_RS1;
        u.op2_sel = (u.br_op == JAL || u.br_op == JALR) ? OP2_IMM : OP2_RS2;
        if (u.op1_sel == OP1_RS1) begin
            pick_source(pct, UOPS_PER_TEST - seq, u.rs1_phy);
        end
        if (u.op2_sel == OP2_RS2) begin
            pick_source(pct, UOPS_PER_TEST - seq, u.rs2_phy);
        end
        u.imm = $urandom;
        u.pc = $urandom & 32'hffff_fffc;
        u.predict_taken = 1'($urandom_range(0, 1));
        u.predict_target = ($urandom_range(0, 1) == 0) ? u.pc + u.imm : $urandom;
        // about one in eight links to p0
        if ($urandom_range(0, 7) != 0) begin
            u.rd_phy = `BR_PREG_IDX'(next_free);
            u.rd_arch = 5'($urandom_range(1, 31));
            reg_ready[next_free] = 1'b0;
            next_free++;
        end
        last_dest = int'(u.rd_phy);
    endtask

    task automatic run_test(input string name, input int mode);
        br_uop_t held_uop;
        logic    have_uop;
        int      seq;
        int      pause_until;
        int      idx;
        int      c0;
        int      e0;
        c0 = checks;
        e0 = errors;
        apply_reset();
        preload_regs();
        seq = 0;
        have_uop = 1'b0;
        held_uop = '0;
        // full-station test starves wakeups until the station has filled
        pause_until = (mode == MODE_FULL) ? cycle + 16 : cycle;
        while (seq < UOPS_PER_TEST || have_uop || resolved < dispatched
               || pending_q.size() > 0) begin
            tick_and_check();
            ext_cdb = '0;
            if (cycle >= pause_until && pending_q.size() > 0 && $urandom_range(0, 2) == 0) begin
                idx = $urandom_range(0, pending_q.size() - 1);
                drive_ext_write(pending_q[idx]);
                pending_q.delete(idx);
            end
            if (!have_uop && seq < UOPS_PER_TEST && !rob_busy[seq % ROB_NUM]) begin
                make_uop(mode, seq, held_uop);
                have_uop = 1'b1;
                seq++;
            end
            dispatch_valid = have_uop;
            if (have_uop) begin
                // readiness follows the renamer every cycle the uop is held
                held_uop.rs1_valid = reg_ready[held_uop.rs1_phy];
                held_uop.rs2_valid = reg_ready[held_uop.rs2_phy];
                dispatch_uop = held_uop;
                if (dispatch_ready) begin
                    rob_uop[held_uop.rob_id] = held_uop;
                    rob_busy[held_uop.rob_id] = 1'b1;
                    dispatched++;
                    have_uop = 1'b0;
                end
            end
        end
        dispatch_valid = 1'b0;
        ext_cdb = '0;
        $display("test %-13s %0d uops, %0d checks, %0d errors",
                 name, dispatched, checks - c0, errors - e0);
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        rst = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_uop = '0;
        ext_cdb = '0;
        cycle = 0;
        checks = 0;
        errors = 0;
        void'($urandom(RNG_SEED));
        run_test("cond_ready", MODE_COND);
        run_test("jal_jalr", MODE_JUMP);
        run_test("mispredict", MODE_PREDICT);
        run_test("wakeup", MODE_WAKEUP);
        run_test("full_station", MODE_FULL);
        $display("summary: %0d tests, %0d checks, %0d errors", N_TESTS, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+hw
hw/br_pkg.sv
hw/br_phys_regfile.sv
hw/br_fu.sv
hw/br_rs.sv
hw/br_issue_top.sv
verification/br_issue_tb.sv

//--- Makefile
VERILATOR       ?= verilator
TOP             ?= br_issue_tb
FILELIST        ?= compile.f
BUILD_DIR       ?= obj_dir
LOG             ?= sim.log
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
